// File: Makefile
# Verilator build and run for the RV32I subset core testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_core
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and address width
`define CORE_XLEN 32

`define CORE_RESET_PC 32'h8000_0000 // first fetch address

`define CORE_REG_COUNT 32 // x0..x31

// major opcodes, inst[6:0]
`define CORE_OP_IMM    7'b001_0011 // addi
`define CORE_OP_LUI    7'b011_0111
`define CORE_OP_AUIPC  7'b001_0111
`define CORE_OP_JAL    7'b110_1111
`define CORE_OP_JALR   7'b110_0111
`define CORE_OP_LOAD   7'b000_0011
`define CORE_OP_STORE  7'b010_0011
`define CORE_OP_SYSTEM 7'b111_0011 // ebreak only

`endif

// File: design/core_pkg.sv
`include "core_config.svh"

package core_pkg;

  // one data word or byte address
  typedef logic [`CORE_XLEN-1:0] word_t;

  typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t; // x0..x31

  typedef logic [`CORE_XLEN/8-1:0] byte_mask_t; // one enable per byte lane

  // encoded as funct3 of loads and stores
  typedef enum logic [2:0] {
    SIZE_BYTE   = 3'b000, // lb, sb
    SIZE_HALF   = 3'b001, // lh, sh
    SIZE_WORD   = 3'b010, // lw, sw
    SIZE_BYTE_U = 3'b100, // lbu
    SIZE_HALF_U = 3'b101  // lhu
  } access_size_t;

  // writeback source for rd
  typedef enum logic [1:0] {
    WB_SUM  = 2'd0, // adder output
    WB_LINK = 2'd1, // pc + 4 for jal and jalr
    WB_LOAD = 2'd2  // extended load data
  } wb_sel_t;

endpackage

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`include "core_config.svh"

module instr_decoder (
  input  core_pkg::word_t        inst,
  output core_pkg::reg_addr_t    rs1_addr,
  output core_pkg::reg_addr_t    rs2_addr,
  output core_pkg::reg_addr_t    rd_addr,
  output core_pkg::word_t        imm,
  output logic                   use_pc,
  output logic                   reg_write,
  output core_pkg::wb_sel_t      wb_sel,
  output logic                   is_load,
  output logic                   is_store,
  output logic                   is_halt,
  output core_pkg::access_size_t size
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  core_pkg::word_t imm_i;
  core_pkg::word_t imm_s;
  core_pkg::word_t imm_u;
  core_pkg::word_t imm_j;
  logic load_ok;  // funct3 names a real load
  logic store_ok; // funct3 names a real store

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  // immediates, sign taken from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign load_ok  = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  assign store_ok = funct3 inside {3'b000, 3'b001, 3'b010};

  // only meaningful when is_load or is_store
  assign size = (load_ok) ? core_pkg::access_size_t'(funct3) : core_pkg::SIZE_WORD;

  always_comb begin
    rs1_addr  = inst[19:15];
    imm       = '0;
    use_pc    = 1'b0;
    reg_write = 1'b0;
    wb_sel    = core_pkg::WB_SUM;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      `CORE_OP_IMM: begin
        imm       = imm_i;
        reg_write = (funct3 == 3'b000); // other op-imm ops only advance pc
      end
      `CORE_OP_LUI: begin
        rs1_addr  = '0; // x0 + imm
        imm       = imm_u;
        reg_write = 1'b1;
      end
      `CORE_OP_AUIPC: begin
        imm       = imm_u;
        use_pc    = 1'b1;
        reg_write = 1'b1;
      end
      `CORE_OP_JAL: begin
        imm       = imm_j;
        use_pc    = 1'b1;
        reg_write = 1'b1;
        wb_sel    = core_pkg::WB_LINK;
      end
      `CORE_OP_JALR: begin
        imm       = imm_i;
        reg_write = 1'b1;
        wb_sel    = core_pkg::WB_LINK;
      end
      `CORE_OP_LOAD: begin
        imm       = imm_i;
        is_load   = load_ok;
        reg_write = load_ok;
        wb_sel    = core_pkg::WB_LOAD;
      end
      `CORE_OP_STORE: begin
        imm      = imm_s;
        is_store = store_ok;
      end
      `CORE_OP_SYSTEM: begin
        // ebreak is funct12 = 1 with every other field zero
        is_halt = (inst[31:7] == 25'h000_2000);
      end
      default: begin
        // unsupported opcode, falls through as a nop
      end
    endcase
  end

endmodule

// File: design/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_load,
  input  logic                   start_store,
  input  core_pkg::access_size_t size,
  input  core_pkg::word_t        addr,
  input  core_pkg::word_t        store_data,
  output core_pkg::word_t        load_data,
  output logic                   done,
  output logic                   mem_req,
  output logic                   mem_we,
  output core_pkg::word_t        mem_addr,
  output core_pkg::word_t        mem_wdata,
  output core_pkg::byte_mask_t   mem_wmask,
  input  logic                   mem_ack,
  input  core_pkg::word_t        mem_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST, // req high, waiting for ack
    ST_RELEASE, // req dropped, waiting for ack low
    ST_DONE
  } state_t;

  state_t state;
  state_t state_next;
  logic start;
  logic misaligned;
  logic [4:0] shamt; // byte offset in bits
  core_pkg::byte_mask_t lane_mask;
  core_pkg::word_t rdata_q; // word captured while ack is high
  core_pkg::word_t lane;

  assign start = start_load | start_store;
  assign shamt = {addr[1:0], 3'b000};

  // lane enables and alignment check
  always_comb begin
    misaligned = 1'b0;
    lane_mask  = '0;
    case (size)
      core_pkg::SIZE_BYTE, core_pkg::SIZE_BYTE_U: begin
        lane_mask = 4'b0001 << addr[1:0];
      end
      core_pkg::SIZE_HALF, core_pkg::SIZE_HALF_U: begin
        misaligned = addr[0];
        lane_mask  = 4'b0011 << addr[1:0];
      end
      core_pkg::SIZE_WORD: begin
        misaligned = (addr[1:0] != 2'b00);
        lane_mask  = 4'b1111;
      end
      default: misaligned = 1'b1;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:    if (start && !misaligned) state_next = ST_REQUEST;
      ST_REQUEST: if (mem_ack) state_next = ST_RELEASE;
      ST_RELEASE: if (!mem_ack) state_next = ST_DONE;
      ST_DONE:    state_next = ST_IDLE;
      default:    state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // bus payload, latched as the transaction opens
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      mem_addr  <= addr;
      mem_we    <= start_store;
      mem_wdata <= store_data << shamt; // data moved into its lane
      mem_wmask <= lane_mask;
    end
    if (state == ST_REQUEST && mem_ack) begin
      rdata_q <= mem_rdata;
    end
  end

  assign mem_req = (state == ST_REQUEST);

  // misaligned access finishes at once with no bus traffic
  assign done = (state == ST_DONE) || (state == ST_IDLE && start && misaligned);

  assign lane = rdata_q >> shamt;

  always_comb begin
    case (size)
      core_pkg::SIZE_BYTE:   load_data = {{24{lane[7]}}, lane[7:0]};
      core_pkg::SIZE_HALF:   load_data = {{16{lane[15]}}, lane[15:0]};
      core_pkg::SIZE_WORD:   load_data = rdata_q;
      core_pkg::SIZE_BYTE_U: load_data = {24'h00_0000, lane[7:0]};
      core_pkg::SIZE_HALF_U: load_data = {16'h0000, lane[15:0]};
      default:               load_data = '0;
    endcase
    if (misaligned) begin
      load_data = '0; // rd gets zero
    end
  end

  // core keeps the same address in front of the lsu for the whole request
  assert property (@(posedge clk) disable iff (rst)
    mem_req |-> (mem_addr == addr))
    else $error("lsu: address changed while mem_req was high");

  // a new request only after the previous ack has gone low
  assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !$past(mem_ack))
    else $error("lsu: mem_req raised while mem_ack still high");

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module register_file (
  input  logic                clk,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data,
  input  logic                we,
  input  core_pkg::reg_addr_t rd_addr,
  input  core_pkg::word_t     rd_data
);

  core_pkg::word_t regs [`CORE_REG_COUNT];

  // x0 reads as zero, whatever the array holds
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

// File: design/rv32_core.sv
`timescale 1ns/1ps
`include "core_config.svh"

module rv32_core (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::word_t      inst,
  output core_pkg::word_t      pc,
  output logic                 halt,
  output logic                 mem_req,
  output logic                 mem_we,
  output core_pkg::word_t      mem_addr,
  output core_pkg::word_t      mem_wdata,
  output core_pkg::byte_mask_t mem_wmask,
  input  logic                 mem_ack,
  input  core_pkg::word_t      mem_rdata
);

  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::reg_addr_t rd_addr;
  core_pkg::word_t imm;
  core_pkg::word_t rs1_data;
  core_pkg::word_t rs2_data;
  core_pkg::word_t load_data;
  core_pkg::word_t op_a;
  core_pkg::word_t sum;
  core_pkg::word_t link;
  core_pkg::word_t target;
  core_pkg::word_t pc_next;
  core_pkg::word_t rd_data;
  core_pkg::wb_sel_t wb_sel;
  core_pkg::access_size_t size;
  logic use_pc;
  logic reg_write;
  logic is_load;
  logic is_store;
  logic is_halt;
  logic lsu_done;
  logic complete; // this edge retires the instruction

  instr_decoder u_decoder (
    .inst      (inst),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .imm       (imm),
    .use_pc    (use_pc),
    .reg_write (reg_write),
    .wb_sel    (wb_sel),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_halt   (is_halt),
    .size      (size)
  );

  register_file u_regfile (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_write && complete),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  load_store_unit u_lsu (
    .clk         (clk),
    .rst         (rst),
    .start_load  (is_load && !halt),
    .start_store (is_store && !halt),
    .size        (size),
    .addr        (sum),
    .store_data  (rs2_data),
    .load_data   (load_data),
    .done        (lsu_done),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wmask   (mem_wmask),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  // one adder for results, jump targets and memory addresses
  assign op_a   = use_pc ? pc : rs1_data;
  assign sum    = op_a + imm;
  assign link   = pc + 32'd4;
  assign target = {sum[`CORE_XLEN-1:1], 1'b0}; // jalr clears bit 0

  // memory ops wait for the lsu, everything else retires now
  assign complete = !halt && ((is_load || is_store) ? lsu_done : 1'b1);

  always_comb begin
    if (wb_sel == core_pkg::WB_LINK) begin
      pc_next = target;
    end else if (is_halt) begin
      pc_next = pc; // freeze on ebreak
    end else begin
      pc_next = link;
    end
  end

  always_comb begin
    case (wb_sel)
      core_pkg::WB_LINK: rd_data = link;
      core_pkg::WB_LOAD: rd_data = load_data;
      default:           rd_data = sum;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `CORE_RESET_PC;
      halt <= 1'b0;
    end else if (complete) begin
      pc <= pc_next;
      if (is_halt) begin
        halt <= 1'b1; // sticky until reset
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("core: pc not word aligned, pc=%h", pc);

endmodule

// File: sources.f
+incdir+design
+incdir+testbench
design/core_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/load_store_unit.sv
design/rv32_core.sv
testbench/tb_core.sv

// File: testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

`include "core_config.svh"

  function automatic core_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // instruction encoders, register numbers and immediates as plain ints
  function automatic core_pkg::word_t enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                            int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic core_pkg::word_t enc_addi(int rd, int rs1, int imm);
    return enc_i(`CORE_OP_IMM, 3'b000, rd, rs1, imm);
  endfunction

  function automatic core_pkg::word_t enc_jalr(int rd, int rs1, int imm);
    return enc_i(`CORE_OP_JALR, 3'b000, rd, rs1, imm);
  endfunction

  function automatic core_pkg::word_t enc_load(core_pkg::access_size_t size, int rd, int rs1,
                                               int imm);
    return enc_i(`CORE_OP_LOAD, size, rd, rs1, imm);
  endfunction

  function automatic core_pkg::word_t enc_store(core_pkg::access_size_t size, int rs2, int rs1,
                                                int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], size, imm[4:0], `CORE_OP_STORE};
  endfunction

  function automatic core_pkg::word_t enc_u(logic [6:0] op, int rd, int imm20);
    return {imm20[19:0], rd[4:0], op}; // lui, auipc
  endfunction

  function automatic core_pkg::word_t enc_jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `CORE_OP_JAL};
  endfunction

  function automatic core_pkg::word_t enc_ebreak();
    return {12'h001, 5'd0, 3'b000, 5'd0, `CORE_OP_SYSTEM};
  endfunction

  task automatic check_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_mask(string name, core_pkg::byte_mask_t got, core_pkg::byte_mask_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_write_count(int count);
    if (wr_addr_q.size() != count) begin
      abort_run($sformatf("expected %0d writes on the data bus but saw %0d",
                          count, wr_addr_q.size()));
    end
  endtask

  // data compared only in the enabled lanes
  task automatic check_write(int idx, core_pkg::word_t addr, core_pkg::byte_mask_t mask,
                             core_pkg::word_t data);
    core_pkg::word_t lanes;
    if (idx >= wr_addr_q.size()) begin
      abort_run($sformatf("bus write number %0d never happened", idx));
    end else begin
      for (int i = 0; i < 4; i++) lanes[8*i +: 8] = {8{mask[i]}};
      check_word("mem_addr", wr_addr_q[idx], addr);
      check_mask("mem_wmask", wr_mask_q[idx], mask);
      check_word("mem_wdata", wr_data_q[idx] & lanes, data & lanes);
    end
  endtask

  // pc must hold until the whole handshake is over
  task automatic check_mem_stall(core_pkg::word_t at_pc);
    bit saw_ack;
    saw_ack = 1'b0;
    run_to(at_pc);
    while (pc === at_pc) begin
      if (mem_ack === 1'b1) saw_ack = 1'b1;
      @(negedge clk);
    end
    if (!saw_ack) begin
      abort_run($sformatf("pc moved on from %h before the memory raised mem_ack", at_pc));
    end else begin
      check_bit("mem_ack", mem_ack, 1'b0);
    end
  endtask

  task automatic test_reset_and_run();
    core_pkg::word_t prog [$];
    prog = {enc_addi(1, 0, 1), enc_addi(2, 1, 2), enc_addi(3, 2, 3), enc_addi(4, 3, 4),
            enc_ebreak()};
    load_program(prog);
    apply_reset();
    check_word("pc", pc, `CORE_RESET_PC);
    check_bit("mem_req", mem_req, 1'b0);
    check_bit("halt", halt, 1'b0);
    for (int k = 1; k <= 4; k++) begin
      @(negedge clk);
      check_word("pc", pc, `CORE_RESET_PC + core_pkg::word_t'(4 * k));
    end
    wait_halt();
  endtask

  task automatic test_alu_results();
    core_pkg::word_t prog [$];
    prog = {enc_u(`CORE_OP_LUI, 10, 'h10), enc_addi(1, 0, 'h123), enc_addi(2, 1, -512),
            enc_u(`CORE_OP_LUI, 3, 'hABCDE), enc_u(`CORE_OP_AUIPC, 4, 'h12),
            enc_store(core_pkg::SIZE_WORD, 1, 10, 0), enc_store(core_pkg::SIZE_WORD, 2, 10, 4),
            enc_store(core_pkg::SIZE_WORD, 3, 10, 8), enc_store(core_pkg::SIZE_WORD, 4, 10, 12),
            enc_ebreak()};
    load_program(prog);
    apply_reset();
    wait_halt();
    check_write_count(4);
    check_write(0, DATA_BASE, 4'hF, 32'h0000_0123);
    check_write(1, DATA_BASE + 32'd4, 4'hF, 32'h0000_0123 + 32'hFFFF_FE00); // -512
    check_write(2, DATA_BASE + 32'd8, 4'hF, 32'hABCDE << 12);
    check_write(3, DATA_BASE + 32'd12, 4'hF, `CORE_RESET_PC + 32'd16 + (32'h12 << 12));
  endtask

  task automatic test_jumps();
    core_pkg::word_t prog [$];
    core_pkg::word_t jal_pc;
    core_pkg::word_t jalr_pc;
    jal_pc = `CORE_RESET_PC + 32'd8;
    jalr_pc = `CORE_RESET_PC + 32'd24;
    // skipped addi slots would overwrite x5
    prog = {enc_u(`CORE_OP_LUI, 10, 'h10), enc_addi(5, 0, 'h55), enc_jal(1, 12),
            enc_addi(5, 0, 1), enc_addi(5, 0, 2), enc_u(`CORE_OP_AUIPC, 7, 0),
            enc_jalr(2, 7, 17), enc_addi(5, 0, 3), enc_addi(5, 0, 4),
            enc_store(core_pkg::SIZE_WORD, 1, 10, 0), enc_store(core_pkg::SIZE_WORD, 2, 10, 4),
            enc_store(core_pkg::SIZE_WORD, 5, 10, 8), enc_ebreak()};
    load_program(prog);
    apply_reset();
    run_to(jal_pc);
    @(negedge clk);
    check_word("pc", pc, jal_pc + 32'd12);
    run_to(jalr_pc);
    @(negedge clk);
    check_word("pc", pc, (`CORE_RESET_PC + 32'd20 + 32'd17) & ~32'h1);
    wait_halt();
    check_write_count(3);
    check_write(0, DATA_BASE, 4'hF, jal_pc + 32'd4);
    check_write(1, DATA_BASE + 32'd4, 4'hF, jalr_pc + 32'd4);
    check_write(2, DATA_BASE + 32'd8, 4'hF, 32'h55);
  endtask

  task automatic test_store_lanes();
    core_pkg::word_t prog [$];
    core_pkg::word_t value;
    value = 32'h8765_4321;
    prog = {enc_u(`CORE_OP_LUI, 10, 'h10), enc_u(`CORE_OP_LUI, 1, 'h87654),
            enc_addi(1, 1, 'h321)};
    for (int i = 0; i < 4; i++) prog.push_back(enc_store(core_pkg::SIZE_BYTE, 1, 10, i));
    prog.push_back(enc_store(core_pkg::SIZE_HALF, 1, 10, 4));
    prog.push_back(enc_store(core_pkg::SIZE_HALF, 1, 10, 6));
    prog.push_back(enc_store(core_pkg::SIZE_WORD, 1, 10, 8));
    prog.push_back(enc_store(core_pkg::SIZE_HALF, 1, 10, 13)); // misaligned
    prog.push_back(enc_store(core_pkg::SIZE_WORD, 1, 10, 18)); // misaligned
    prog.push_back(enc_store(core_pkg::SIZE_WORD, 1, 10, 16));
    prog.push_back(enc_ebreak());
    load_program(prog);
    apply_reset();
    wait_halt();
    check_write_count(8);
    for (int i = 0; i < 4; i++) begin
      check_write(i, DATA_BASE + core_pkg::word_t'(i), core_pkg::byte_mask_t'(1 << i),
                  {4{value[7:0]}});
    end
    check_write(4, DATA_BASE + 32'd4, 4'b0011, {2{value[15:0]}});
    check_write(5, DATA_BASE + 32'd6, 4'b1100, {2{value[15:0]}});
    check_write(6, DATA_BASE + 32'd8, 4'b1111, value);
    check_write(7, DATA_BASE + 32'd16, 4'b1111, value);
  endtask

  task automatic test_loads();
    core_pkg::word_t prog [$];
    core_pkg::word_t words [3];
    core_pkg::access_size_t sizes [9];
    int offs [9];
    core_pkg::word_t expected [9];
    core_pkg::word_t lane;
    words[0] = lcg_next() | 32'h8080_8080; // every lane negative
    words[1] = lcg_next() & 32'h7F7F_7F7F; // every lane positive
    words[2] = lcg_next();
    sizes = '{core_pkg::SIZE_BYTE, core_pkg::SIZE_HALF, core_pkg::SIZE_WORD,
              core_pkg::SIZE_BYTE_U, core_pkg::SIZE_HALF_U, core_pkg::SIZE_BYTE,
              core_pkg::SIZE_HALF, core_pkg::SIZE_HALF_U, core_pkg::SIZE_WORD};
    offs = '{1, 2, 4, 3, 0, 6, 8, 10, 9}; // last one misaligned
    prog = {enc_u(`CORE_OP_LUI, 10, 'h10)};
    for (int i = 0; i < 9; i++) prog.push_back(enc_load(sizes[i], i + 1, 10, offs[i]));
    for (int i = 0; i < 9; i++) begin
      prog.push_back(enc_store(core_pkg::SIZE_WORD, i + 1, 10, 'h100 + 4 * i));
    end
    prog.push_back(enc_ebreak());
    load_program(prog);
    for (int k = 0; k < 3; k++) dmem[DATA_BASE + core_pkg::word_t'(4 * k)] = words[k];
    for (int i = 0; i < 9; i++) begin
      lane = words[offs[i] / 4] >> (8 * (offs[i] % 4));
      case (sizes[i])
        core_pkg::SIZE_BYTE:   expected[i] = 32'($signed(lane[7:0]));
        core_pkg::SIZE_HALF:   expected[i] = 32'($signed(lane[15:0]));
        core_pkg::SIZE_BYTE_U: expected[i] = 32'(lane[7:0]);
        core_pkg::SIZE_HALF_U: expected[i] = 32'(lane[15:0]);
        default:               expected[i] = (offs[i] % 4 == 0) ? lane : '0;
      endcase
    end
    apply_reset();
    for (int i = 0; i < 8; i++) check_mem_stall(`CORE_RESET_PC + core_pkg::word_t'(4 + 4 * i));
    // misaligned lw retires in one cycle without a request
    run_to(`CORE_RESET_PC + 32'd36);
    @(negedge clk);
    check_word("pc", pc, `CORE_RESET_PC + 32'd40);
    check_bit("mem_req", mem_req, 1'b0);
    wait_halt();
    check_write_count(9);
    for (int i = 0; i < 9; i++) begin
      check_write(i, DATA_BASE + core_pkg::word_t'('h100 + 4 * i), 4'hF, expected[i]);
    end
  endtask

  task automatic test_halt();
    core_pkg::word_t prog [$];
    prog = {enc_addi(1, 0, 7), enc_ebreak(), enc_addi(2, 0, 1)};
    load_program(prog);
    apply_reset();
    @(negedge clk);
    check_word("pc", pc, `CORE_RESET_PC + 32'd4);
    check_bit("halt", halt, 1'b0);
    @(negedge clk);
    check_bit("halt", halt, 1'b1);
    repeat (10) begin
      @(negedge clk);
      check_word("pc", pc, `CORE_RESET_PC + 32'd4);
      check_bit("halt", halt, 1'b1);
      check_bit("mem_req", mem_req, 1'b0);
    end
  endtask

`endif

// File: testbench/tb_core.sv
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core;

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int IMEM_WORDS = 256;
  localparam core_pkg::word_t DATA_BASE = 32'h0001_0000; // lui x10, 0x10

  logic clk;
  logic rst;
  core_pkg::word_t inst;
  core_pkg::word_t pc;
  logic halt;
  logic mem_req;
  logic mem_we;
  core_pkg::word_t mem_addr;
  core_pkg::word_t mem_wdata;
  core_pkg::byte_mask_t mem_wmask;
  logic mem_ack;
  core_pkg::word_t mem_rdata;

  core_pkg::word_t imem [IMEM_WORDS];
  core_pkg::word_t dmem [core_pkg::word_t]; // keyed by aligned byte address
  core_pkg::word_t wr_addr_q [$];           // every bus write, in order
  core_pkg::byte_mask_t wr_mask_q [$];
  core_pkg::word_t wr_data_q [$];
  core_pkg::word_t lcg_state;
  core_pkg::word_t pc_offset;
  bit mem_busy;          // request seen, ack still pending
  int unsigned ack_wait; // cycles left before ack

  rv32_core DUT (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .pc        (pc),
    .halt      (halt),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fetch is combinational, ebreak outside the program window
  assign pc_offset = pc - `CORE_RESET_PC;
  assign inst = (pc_offset[31:10] == '0) ? imem[pc_offset[9:2]] : enc_ebreak();

  function automatic core_pkg::word_t dmem_read(core_pkg::word_t addr);
    core_pkg::word_t waddr;
    waddr = {addr[31:2], 2'b00};
    if (dmem.exists(waddr)) begin
      return dmem[waddr];
    end
    return waddr ^ 32'h5A5A_C3C3; // untouched words
  endfunction

  task automatic answer_request();
    core_pkg::word_t waddr;
    core_pkg::word_t word;
    waddr = {mem_addr[31:2], 2'b00};
    word = dmem_read(mem_addr);
    mem_ack <= 1'b1;
    if (mem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_wmask[i]) word[8*i +: 8] = mem_wdata[8*i +: 8];
      end
      dmem[waddr] = word;
      wr_addr_q.push_back(mem_addr);
      wr_mask_q.push_back(mem_wmask);
      wr_data_q.push_back(mem_wdata);
    end else begin
      mem_rdata <= word;
    end
  endtask

  // four-phase slave with a random ack delay of 0 to 5 cycles
  always @(posedge clk) begin
    if (rst) begin
      mem_ack <= 1'b0;
      mem_busy = 1'b0;
    end else if (mem_req && !mem_ack) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        ack_wait = (lcg_next() >> 16) % 6;
      end
      if (ack_wait == 0) begin
        mem_busy = 1'b0;
        answer_request();
      end else begin
        ack_wait--;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0;
    end
  end

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic load_program(input core_pkg::word_t prog [$]);
    foreach (imem[i]) imem[i] = enc_ebreak();
    foreach (prog[i]) imem[i] = prog[i];
    dmem.delete();
    wr_addr_q.delete();
    wr_mask_q.delete();
    wr_data_q.delete();
  endtask

  // ends at the falling edge right after rst drops
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_to(core_pkg::word_t at_pc);
    while (pc !== at_pc) @(negedge clk);
  endtask

  task automatic wait_halt();
    while (halt !== 1'b1) @(negedge clk);
  endtask

  `include "tb_tasks.svh"

  initial begin
    rst <= 1'b1;
    mem_ack <= 1'b0;
    mem_rdata <= '0;
    lcg_state = 32'd18322;
    test_reset_and_run();
    test_alu_results();
    test_jumps();
    test_store_lanes();
    test_loads();
    test_halt();
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("TB FAILED");
    $fatal(1, "simulation timeout");
  end

endmodule
